/* logic/cpu_memory_pkg.sv */
`default_nettype none

package cpu_memory_pkg;

	// ********************
	// Datapath
	// ********************

	localparam int DATA_WIDTH = 32;	// Addresses and data words
	localparam int TAG_WIDTH = 8;	// Pipeline tag

	// ********************
	// Access widths
	// ********************

	// Size of the access in bytes
	localparam logic [2:0] WIDTH_BYTE = 3'd1;
	localparam logic [2:0] WIDTH_HALF = 3'd2;
	localparam logic [2:0] WIDTH_WORD = 3'd4;

	// ********************
	// Address map
	// ********************

	// SDRAM window matched against address bits 31..28
	localparam logic [3:0] CACHEABLE_REGION = 4'h2;

endpackage

`default_nettype wire

/* logic/cpu_memory_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_memory_stage import cpu_memory_pkg::*; (
	input wire i_clock,
	input wire i_reset,

	// Execute stage side
	input wire [TAG_WIDTH-1:0] i_tag,
	input wire i_mem_read,
	input wire i_mem_write,
	input wire i_mem_flush,
	input wire [2:0] i_mem_width,
	input wire i_mem_signed,
	input wire [DATA_WIDTH-1:0] i_mem_address,
	input wire [DATA_WIDTH-1:0] i_rd,
	input wire [4:0] i_inst_rd,

	output wire o_busy,
	output logic [TAG_WIDTH-1:0] o_tag,
	output logic [DATA_WIDTH-1:0] o_rd,
	output logic [4:0] o_inst_rd,

	// Data cache side
	output logic o_dc_request,
	output logic o_dc_rw,
	output logic o_dc_flush,
	output wire [DATA_WIDTH-1:0] o_dc_address,
	output logic [DATA_WIDTH-1:0] o_dc_wdata,
	input wire i_dc_ready,
	input wire [DATA_WIDTH-1:0] i_dc_rdata
);

	typedef enum logic [2:0] {
		IDLE,
		READ,
		WRITE_WORD,
		RMW_READ,
		RMW_WRITE,
		FLUSH
	} state_t;

	state_t state;
	state_t next_state;
	logic complete;
	logic [DATA_WIDTH-1:0] rmw_rdata;
	logic [DATA_WIDTH-1:0] load_value;

	wire new_op = (i_tag != o_tag);
	wire [4:0] lane_shift = {i_mem_address[1:0], 3'b000};

	// Lane extraction for loads
	wire [DATA_WIDTH-1:0] rdata_shifted = i_dc_rdata >> lane_shift;
	wire [7:0] rdata_byte = rdata_shifted[7:0];
	wire [15:0] rdata_half = rdata_shifted[15:0];

	// Lane merge for sub-word stores
	wire [DATA_WIDTH-1:0] lane_mask =
		((i_mem_width == WIDTH_BYTE) ? 32'h0000_00ff : 32'h0000_ffff) << lane_shift;
	wire [DATA_WIDTH-1:0] merged_wdata =
		(rmw_rdata & ~lane_mask) | ((i_rd << lane_shift) & lane_mask);

	assign o_busy = new_op && (i_mem_read || i_mem_write || i_mem_flush);
	assign o_dc_address = {i_mem_address[DATA_WIDTH-1:2], 2'b00};

	always_comb begin
		case (i_mem_width)
			WIDTH_WORD: load_value = i_dc_rdata;
			WIDTH_HALF: load_value = {{16{i_mem_signed & rdata_half[15]}}, rdata_half};
			WIDTH_BYTE: load_value = {{24{i_mem_signed & rdata_byte[7]}}, rdata_byte};
			default: load_value = '0;
		endcase
	end

	// ********************
	// Control
	// ********************

	always_comb begin
		next_state = state;
		complete = 1'b0;
		o_dc_request = 1'b0;
		o_dc_rw = 1'b0;
		o_dc_flush = 1'b0;
		o_dc_wdata = i_rd;

		case (state)
			IDLE: begin
				if (new_op) begin
					if (i_mem_read) begin
						o_dc_request = 1'b1;
						next_state = READ;
					end else if (i_mem_write) begin
						o_dc_request = 1'b1;
						if (i_mem_width == WIDTH_WORD) begin
							o_dc_rw = 1'b1;
							next_state = WRITE_WORD;
						end else begin
							next_state = RMW_READ;	// Bus only takes whole words
						end
					end else if (i_mem_flush) begin
						o_dc_request = 1'b1;
						o_dc_flush = 1'b1;
						next_state = FLUSH;
					end else begin
						complete = 1'b1;	// Pass-through
					end
				end
			end

			READ, RMW_READ: begin
				o_dc_request = 1'b1;
				if (i_dc_ready)
					next_state = (state == READ) ? IDLE : RMW_WRITE;
				complete = i_dc_ready && (state == READ);
			end

			WRITE_WORD, RMW_WRITE: begin
				o_dc_request = 1'b1;
				o_dc_rw = 1'b1;
				if (state == RMW_WRITE)
					o_dc_wdata = merged_wdata;
				if (i_dc_ready) begin
					complete = 1'b1;
					next_state = IDLE;
				end
			end

			FLUSH: begin
				o_dc_request = 1'b1;
				o_dc_flush = 1'b1;
				if (i_dc_ready) begin
					complete = 1'b1;
					next_state = IDLE;
				end
			end

			default: next_state = IDLE;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= IDLE;
			o_tag <= '0;
			o_rd <= '0;
			o_inst_rd <= '0;
		end else begin
			state <= next_state;
			if (complete) begin
				o_tag <= i_tag;
				o_rd <= (state == READ) ? load_value : i_rd;
				o_inst_rd <= i_inst_rd;
			end
		end
	end

	// Word read back for the merge
	always_ff @(posedge i_clock) begin
		if (state == RMW_READ && i_dc_ready)
			rmw_rdata <= i_dc_rdata;
	end

endmodule

`default_nettype wire

/* logic/cpu_dcache.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_dcache import cpu_memory_pkg::*; #(
	parameter int DCACHE_LINES = 64	// Power of two
) (
	input wire i_clock,
	input wire i_reset,

	// Memory stage side
	input wire i_request,
	input wire i_rw,
	input wire i_flush,
	input wire [DATA_WIDTH-1:0] i_address,
	input wire [DATA_WIDTH-1:0] i_wdata,
	output wire o_ready,
	output wire [DATA_WIDTH-1:0] o_rdata,

	// External bus
	output logic o_bus_request,
	output logic o_bus_rw,
	output logic [DATA_WIDTH-1:0] o_bus_address,
	output logic [DATA_WIDTH-1:0] o_bus_wdata,
	input wire i_bus_ready,
	input wire [DATA_WIDTH-1:0] i_bus_rdata
);

	localparam int INDEX_BITS = $clog2(DCACHE_LINES);
	localparam int TAG_BITS = DATA_WIDTH - INDEX_BITS - 2;

	typedef enum logic [2:0] {
		C_IDLE,
		C_WRITEBACK,
		C_FILL,
		C_BYPASS,
		C_FLUSH,
		C_DONE
	} state_t;

	state_t state;

	logic [DATA_WIDTH-1:0] data_mem [DCACHE_LINES];
	logic [TAG_BITS-1:0] tag_mem [DCACHE_LINES];
	logic [DCACHE_LINES-1:0] valid;
	logic [DCACHE_LINES-1:0] dirty;
	logic [INDEX_BITS-1:0] flush_index;
	logic [DATA_WIDTH-1:0] rdata_q;
	logic mem_we;
	logic [DATA_WIDTH-1:0] mem_wdata;

	wire [INDEX_BITS-1:0] index = i_address[INDEX_BITS+1:2];
	wire [TAG_BITS-1:0] addr_tag = i_address[DATA_WIDTH-1:INDEX_BITS+2];
	wire cacheable = (i_address[DATA_WIDTH-1:DATA_WIDTH-4] == CACHEABLE_REGION);
	wire hit = valid[index] && (tag_mem[index] == addr_tag);
	wire needs_writeback = valid[index] && dirty[index] && !hit;	// Dirty victim

	wire flush_dirty = valid[flush_index] && dirty[flush_index];
	wire flush_last = (flush_index == INDEX_BITS'(DCACHE_LINES - 1));
	wire flush_step = o_bus_request ? i_bus_ready : !flush_dirty;

	assign o_ready = (state == C_DONE);
	assign o_rdata = rdata_q;

	// Line writes
	always_comb begin
		mem_we = 1'b0;
		mem_wdata = i_wdata;
		case (state)
			C_IDLE: mem_we = i_request && !i_flush && cacheable && i_rw && !needs_writeback;
			C_WRITEBACK: mem_we = i_bus_ready && i_rw;
			C_FILL: begin
				mem_we = o_bus_request && i_bus_ready;
				mem_wdata = i_bus_rdata;
			end
			default: mem_we = 1'b0;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (mem_we) begin
			data_mem[index] <= mem_wdata;
			tag_mem[index] <= addr_tag;
		end
		// Held while ready is up
		if (state != C_DONE)
			rdata_q <= (state == C_IDLE) ? data_mem[index] : i_bus_rdata;
	end

	// ********************
	// Controller
	// ********************

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= C_IDLE;
			valid <= '0;
			dirty <= '0;
			flush_index <= '0;
			o_bus_request <= 1'b0;
			o_bus_rw <= 1'b0;
			o_bus_address <= '0;
			o_bus_wdata <= '0;
		end else begin
			case (state)
				C_IDLE: begin
					if (i_request) begin
						if (i_flush) begin
							flush_index <= '0;
							state <= C_FLUSH;
						end else if (!cacheable) begin
							o_bus_request <= 1'b1;
							o_bus_rw <= i_rw;
							o_bus_address <= {i_address[DATA_WIDTH-1:2], 2'b00};
							o_bus_wdata <= i_wdata;
							state <= C_BYPASS;
						end else if (needs_writeback) begin
							o_bus_request <= 1'b1;
							o_bus_rw <= 1'b1;
							o_bus_address <= {tag_mem[index], index, 2'b00};
							o_bus_wdata <= data_mem[index];
							state <= C_WRITEBACK;
						end else if (i_rw) begin
							valid[index] <= 1'b1;	// Whole line written so no fill
							dirty[index] <= 1'b1;
							state <= C_DONE;
						end else begin
							state <= hit ? C_DONE : C_FILL;
						end
					end
				end

				C_WRITEBACK: begin
					if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						if (i_rw) begin
							dirty[index] <= 1'b1;
							state <= C_DONE;
						end else begin
							dirty[index] <= 1'b0;
							state <= C_FILL;
						end
					end
				end

				C_FILL: begin
					if (!o_bus_request) begin
						o_bus_request <= 1'b1;
						o_bus_rw <= 1'b0;
						o_bus_address <= {i_address[DATA_WIDTH-1:2], 2'b00};
					end else if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						valid[index] <= 1'b1;
						dirty[index] <= 1'b0;
						state <= C_DONE;
					end
				end

				C_BYPASS: begin
					if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						state <= C_DONE;
					end
				end

				C_FLUSH: begin
					if (!o_bus_request && flush_dirty) begin
						o_bus_request <= 1'b1;
						o_bus_rw <= 1'b1;
						o_bus_address <= {tag_mem[flush_index], flush_index, 2'b00};
						o_bus_wdata <= data_mem[flush_index];
					end
					if (flush_step) begin
						o_bus_request <= 1'b0;
						valid[flush_index] <= 1'b0;
						dirty[flush_index] <= 1'b0;
						if (flush_last)
							state <= C_DONE;
						else
							flush_index <= flush_index + 1'b1;
					end
				end

				C_DONE: state <= C_IDLE;

				default: state <= C_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* logic/cpu_memory_subsystem.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_memory_subsystem import cpu_memory_pkg::*; #(
	parameter int DCACHE_LINES = 64
) (
	input wire i_clock,
	input wire i_reset,

	// Pipeline
	input wire [TAG_WIDTH-1:0] i_tag,
	input wire i_mem_read,
	input wire i_mem_write,
	input wire i_mem_flush,
	input wire [2:0] i_mem_width,
	input wire i_mem_signed,
	input wire [DATA_WIDTH-1:0] i_mem_address,
	input wire [DATA_WIDTH-1:0] i_rd,
	input wire [4:0] i_inst_rd,
	output wire o_busy,
	output wire [TAG_WIDTH-1:0] o_tag,
	output wire [DATA_WIDTH-1:0] o_rd,
	output wire [4:0] o_inst_rd,

	// External word bus
	output wire o_bus_request,
	output wire o_bus_rw,
	output wire [DATA_WIDTH-1:0] o_bus_address,
	output wire [DATA_WIDTH-1:0] o_bus_wdata,
	input wire i_bus_ready,
	input wire [DATA_WIDTH-1:0] i_bus_rdata
);

	// Stage to cache
	wire dc_request;
	wire dc_rw;
	wire dc_flush;
	wire dc_ready;
	wire [DATA_WIDTH-1:0] dc_address;
	wire [DATA_WIDTH-1:0] dc_wdata;
	wire [DATA_WIDTH-1:0] dc_rdata;

	cpu_memory_stage u_stage (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_tag(i_tag),
		.i_mem_read(i_mem_read),
		.i_mem_write(i_mem_write),
		.i_mem_flush(i_mem_flush),
		.i_mem_width(i_mem_width),
		.i_mem_signed(i_mem_signed),
		.i_mem_address(i_mem_address),
		.i_rd(i_rd),
		.i_inst_rd(i_inst_rd),
		.o_busy(o_busy),
		.o_tag(o_tag),
		.o_rd(o_rd),
		.o_inst_rd(o_inst_rd),
		.o_dc_request(dc_request),
		.o_dc_rw(dc_rw),
		.o_dc_flush(dc_flush),
		.o_dc_address(dc_address),
		.o_dc_wdata(dc_wdata),
		.i_dc_ready(dc_ready),
		.i_dc_rdata(dc_rdata)
	);

	cpu_dcache #(
		.DCACHE_LINES(DCACHE_LINES)
	) u_dcache (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(dc_request),
		.i_rw(dc_rw),
		.i_flush(dc_flush),
		.i_address(dc_address),
		.i_wdata(dc_wdata),
		.o_ready(dc_ready),
		.o_rdata(dc_rdata),
		.o_bus_request(o_bus_request),
		.o_bus_rw(o_bus_rw),
		.o_bus_address(o_bus_address),
		.o_bus_wdata(o_bus_wdata),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata)
	);

endmodule

`default_nettype wire

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD = 8,
	parameter int RESET_CYCLES = 10
) (
	output logic o_clock,
	output logic o_reset
);

	initial begin
		o_clock = 1'b0;
		forever #(PERIOD / 2) o_clock = ~o_clock;
	end

	initial begin
		o_reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge o_clock);
		o_reset <= 1'b0;
	end

endmodule

`default_nettype wire

/* tb/cpu_memory_properties.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_memory_properties import cpu_memory_pkg::*; (
	input wire i_clock,
	input wire i_reset,
	input wire i_bus_request,
	input wire [DATA_WIDTH-1:0] i_bus_address,
	input wire i_bus_ready,
	input wire i_busy,
	input wire i_dc_request,
	input wire i_dc_ready
);

	// Bus request waits for ready with a fixed address
	bus_request_held: assert property (@(posedge i_clock) disable iff (i_reset)
		i_bus_request && !i_bus_ready |=> i_bus_request && $stable(i_bus_address))
		else $error("bus request dropped or address changed before ready");

	busy_low_in_reset: assert property (@(posedge i_clock) i_reset |-> !i_busy)
		else $error("o_busy high during reset");

	// Cache only answers a pending request
	ready_needs_request: assert property (@(posedge i_clock) disable iff (i_reset)
		$rose(i_dc_ready) |-> i_dc_request)
		else $error("dc_ready rose without dc_request");

endmodule

bind cpu_memory_subsystem cpu_memory_properties u_properties (
	.i_clock(i_clock),
	.i_reset(i_reset),
	.i_bus_request(o_bus_request),
	.i_bus_address(o_bus_address),
	.i_bus_ready(i_bus_ready),
	.i_busy(o_busy),
	.i_dc_request(dc_request),
	.i_dc_ready(dc_ready)
);

`default_nettype wire

/* tb/tb_memory_subsystem.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_memory_subsystem import cpu_memory_pkg::*; ();

	localparam logic [2:0] OP_PASS = 3'd0;
	localparam logic [2:0] OP_LOAD = 3'd1;
	localparam logic [2:0] OP_STORE = 3'd2;
	localparam logic [2:0] OP_FLUSH = 3'd3;
	localparam logic [2:0] OP_MEMCHK = 3'd4;	// Backing word compare only

	typedef struct packed {
		logic [2:0] op;
		logic [2:0] width;
		logic sgn;
		logic chk;
		logic [2:0] test;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] exp_rd;
		logic [31:0] exp_mem;
	} row_t;

	wire clock;
	wire reset;
	logic [TAG_WIDTH-1:0] i_tag;
	logic i_mem_read;
	logic i_mem_write;
	logic i_mem_flush;
	logic [2:0] i_mem_width;
	logic i_mem_signed;
	logic [31:0] i_mem_address;
	logic [31:0] i_rd;
	logic [4:0] i_inst_rd;
	wire o_busy;
	wire [TAG_WIDTH-1:0] o_tag;
	wire [31:0] o_rd;
	wire [4:0] o_inst_rd;
	wire o_bus_request;
	wire o_bus_rw;
	wire [31:0] o_bus_address;
	wire [31:0] o_bus_wdata;
	logic i_bus_ready = 1'b0;
	logic [31:0] i_bus_rdata = '0;

	int seed = 41708;
	int wait_count = 0;
	int cycle_count = 0;
	int timeout_limit = 0;
	int build_test = 0;
	int errors = 0;
	int checks = 0;
	int test_errors = 0;
	row_t table_q [$];
	logic [31:0] bus_mem [logic [31:0]];
	logic [31:0] ref_mem [logic [31:0]];
	bit pending [logic [31:0]];	// Cacheable words stored since the last flush
	string test_names [6] = '{"word store and load", "sub-word stores", "uncacheable access",
		"write-back and flush", "pass-through", "random mix"};

	tb_clock_gen #(.PERIOD(8), .RESET_CYCLES(10)) u_clock_gen (
		.o_clock(clock),
		.o_reset(reset)
	);

	cpu_memory_subsystem #(.DCACHE_LINES(64)) u_dut (
		.i_clock(clock), .i_reset(reset),
		.i_tag(i_tag), .i_mem_read(i_mem_read), .i_mem_write(i_mem_write),
		.i_mem_flush(i_mem_flush), .i_mem_width(i_mem_width), .i_mem_signed(i_mem_signed),
		.i_mem_address(i_mem_address), .i_rd(i_rd), .i_inst_rd(i_inst_rd),
		.o_busy(o_busy), .o_tag(o_tag), .o_rd(o_rd), .o_inst_rd(o_inst_rd),
		.o_bus_request(o_bus_request), .o_bus_rw(o_bus_rw), .o_bus_address(o_bus_address),
		.o_bus_wdata(o_bus_wdata), .i_bus_ready(i_bus_ready), .i_bus_rdata(i_bus_rdata)
	);

	function automatic logic [31:0] fill_word(input logic [31:0] a);
		return {a[15:0], a[31:16]} ^ 32'h5a3c_96e1;
	endfunction

	function automatic logic [31:0] bus_word(input logic [31:0] a);
		if (bus_mem.exists(a))
			return bus_mem[a];
		return fill_word(a);
	endfunction

	function automatic logic [31:0] ref_word(input logic [31:0] a);
		if (ref_mem.exists(a))
			return ref_mem[a];
		return fill_word(a);
	endfunction

	// ********************
	// Bus memory model
	// ********************

	always @(posedge clock) begin
		if (reset) begin
			i_bus_ready <= 1'b0;
			wait_count <= 0;
		end else if (o_bus_request && !i_bus_ready) begin
			if (wait_count == 0) begin
				i_bus_ready <= 1'b1;
				if (o_bus_rw)
					bus_mem[o_bus_address] = o_bus_wdata;
				else
					i_bus_rdata <= bus_word(o_bus_address);
				wait_count <= $random(seed) & 3;	// Wait states for the next one
			end else begin
				wait_count <= wait_count - 1;
			end
		end else begin
			i_bus_ready <= 1'b0;
		end
	end

	always @(posedge clock)
		cycle_count <= cycle_count + 1;

	initial begin
		wait (timeout_limit > 0);
		while (cycle_count < timeout_limit)
			@(posedge clock);
		$display("Timeout: run stopped after %0d cycles without finishing", cycle_count);
		$display("Some tests failed");
		$finish;
	end

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		checks++;
		if (actual !== expected) begin
			$display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
			errors++;
			test_errors++;
		end
	endtask

	// ********************
	// Stimulus table
	// ********************

	// Expected values follow the byte-lane rules on the reference memory
	task automatic add_row(input logic [2:0] op, input logic [2:0] width, input logic sgn,
			input logic [31:0] addr, input logic [31:0] data, input logic chk);
		row_t r;
		logic [31:0] wa;
		logic [31:0] word;
		int lane;
		wa = {addr[31:2], 2'b00};
		lane = int'(addr[1:0]);
		word = ref_word(wa);
		r = '0;
		r.op = op;
		r.width = width;
		r.sgn = sgn;
		r.chk = chk;
		r.test = 3'(build_test);
		r.addr = addr;
		r.data = data;
		r.exp_rd = data;
		if (op == OP_LOAD) begin
			if (width == WIDTH_WORD) begin
				r.exp_rd = word;
			end else if (width == WIDTH_HALF) begin
				r.exp_rd = {16'h0000, word[8*lane +: 16]};
				if (sgn && word[8*lane+15])
					r.exp_rd[31:16] = 16'hffff;
			end else begin
				r.exp_rd = {24'h000000, word[8*lane +: 8]};
				if (sgn && word[8*lane+7])
					r.exp_rd[31:8] = 24'hffffff;
			end
		end else if (op == OP_STORE) begin
			if (width == WIDTH_WORD)
				word = data;
			else if (width == WIDTH_HALF)
				word[8*lane +: 16] = data[15:0];
			else
				word[8*lane +: 8] = data[7:0];
			ref_mem[wa] = word;
			if (addr[31:28] == CACHEABLE_REGION) begin
				pending[wa] = 1'b1;
				r.exp_mem = fill_word(wa);	// Still only in the cache
			end else begin
				r.exp_mem = word;
			end
		end
		table_q.push_back(r);
		if (op == OP_FLUSH) begin
			foreach (pending[a]) begin
				r.op = OP_MEMCHK;
				r.addr = a;
				r.exp_mem = ref_word(a);
				table_q.push_back(r);
			end
			pending.delete();
		end
	endtask

	task automatic build_table();
		logic [31:0] rnd;
		logic [31:0] addr;
		logic [2:0] width;
		logic [2:0] op;
		logic [7:0] b;
		build_test = 0;
		add_row(OP_STORE, WIDTH_WORD, 0, 32'h2000_0010, 32'h1122_3344, 0);
		add_row(OP_LOAD, WIDTH_WORD, 0, 32'h2000_0010, 32'h0, 0);
		add_row(OP_STORE, WIDTH_WORD, 0, 32'h2000_0110, 32'hdead_beef, 0);	// Same line index
		add_row(OP_LOAD, WIDTH_WORD, 0, 32'h2000_0010, 32'h0, 0);
		add_row(OP_LOAD, WIDTH_WORD, 0, 32'h2000_0110, 32'h0, 0);
		add_row(OP_LOAD, WIDTH_WORD, 0, 32'h2000_0040, 32'h0, 0);
		build_test = 1;
		add_row(OP_STORE, WIDTH_WORD, 0, 32'h2000_0020, 32'h0102_0304, 0);
		for (int k = 0; k < 4; k++) begin
			b = 8'h3c + 8'(k) * 8'h51;
			add_row(OP_STORE, WIDTH_BYTE, 0, 32'h2000_0020 + k, 32'hc0ff_ee00 | 32'(b), 0);
		end
		for (int k = 0; k < 8; k++)
			add_row(OP_LOAD, WIDTH_BYTE, k[0], 32'h2000_0020 + k / 2, 32'h0, 0);
		add_row(OP_STORE, WIDTH_WORD, 0, 32'h2000_0024, 32'h1357_9bdf, 0);
		add_row(OP_STORE, WIDTH_HALF, 0, 32'h2000_0024, 32'haaaa_8001, 0);
		add_row(OP_STORE, WIDTH_HALF, 0, 32'h2000_0026, 32'h5555_7ffe, 0);
		for (int k = 0; k < 4; k++)
			add_row(OP_LOAD, WIDTH_HALF, k[0], 32'h2000_0024 + 2 * (k / 2), 32'h0, 0);
		add_row(OP_LOAD, WIDTH_WORD, 0, 32'h2000_0024, 32'h0, 0);
		build_test = 2;
		add_row(OP_STORE, WIDTH_WORD, 0, 32'h1000_0100, 32'hcafe_f00d, 1);
		add_row(OP_STORE, WIDTH_BYTE, 0, 32'h1000_0102, 32'h0000_0042, 1);
		add_row(OP_STORE, WIDTH_HALF, 0, 32'h1000_0106, 32'h0000_9abc, 1);
		add_row(OP_LOAD, WIDTH_WORD, 0, 32'h1000_0100, 32'h0, 0);
		add_row(OP_LOAD, WIDTH_HALF, 1, 32'h1000_0202, 32'h0, 0);
		add_row(OP_LOAD, WIDTH_BYTE, 0, 32'h1000_0203, 32'h0, 0);
		build_test = 3;
		add_row(OP_STORE, WIDTH_WORD, 0, 32'h2000_0800, 32'h0bad_cafe, 1);
		add_row(OP_STORE, WIDTH_HALF, 0, 32'h2000_0a06, 32'h0000_c3d2, 1);
		add_row(OP_STORE, WIDTH_BYTE, 0, 32'h2000_0c33, 32'h0000_00e7, 1);
		add_row(OP_FLUSH, WIDTH_WORD, 0, 32'h0, 32'h0000_0777, 0);
		add_row(OP_LOAD, WIDTH_WORD, 0, 32'h2000_0800, 32'h0, 0);
		build_test = 4;
		add_row(OP_PASS, WIDTH_WORD, 0, 32'h2000_0010, 32'h1234_5678, 0);
		add_row(OP_PASS, WIDTH_BYTE, 1, 32'h1000_0000, 32'h8765_4321, 0);
		add_row(OP_PASS, WIDTH_HALF, 0, 32'h0, 32'hffff_0000, 0);
		build_test = 5;
		for (int k = 0; k < 150; k++) begin
			rnd = $random(seed);
			addr = {rnd[0] ? CACHEABLE_REGION : 4'h1, 18'h0, rnd[11:2]};
			width = (rnd[13:12] == 2'd0) ? WIDTH_BYTE :
				(rnd[13:12] == 2'd1) ? WIDTH_HALF : WIDTH_WORD;
			if (width == WIDTH_HALF)
				addr[0] = 1'b0;
			else if (width == WIDTH_WORD)
				addr[1:0] = 2'b00;
			op = (rnd[19:16] < 4'd7) ? OP_LOAD : (rnd[19:16] < 4'd14) ? OP_STORE :
				(rnd[19:16] == 4'd14) ? OP_PASS : OP_FLUSH;
			add_row(op, width, rnd[20], addr, $random(seed), 0);
		end
		add_row(OP_FLUSH, WIDTH_WORD, 0, 32'h0, 32'h0, 0);
	endtask

	// ********************
	// Apply the table
	// ********************

	initial begin
		row_t r;
		logic [7:0] tag;
		int test_rows;
		i_tag = '0;
		i_mem_read = 1'b0;
		i_mem_write = 1'b0;
		i_mem_flush = 1'b0;
		i_mem_width = WIDTH_WORD;
		i_mem_signed = 1'b0;
		i_mem_address = '0;
		i_rd = '0;
		i_inst_rd = '0;
		tag = 8'h00;
		test_rows = 0;
		build_table();
		timeout_limit = 200 * table_q.size();
		@(posedge clock);
		i_mem_read <= 1'b1;	// Flag up while reset holds both tags at zero
		while (reset)
			@(posedge clock);
		for (int i = 0; i < table_q.size(); i++) begin
			r = table_q[i];
			test_rows++;
			if (r.op == OP_MEMCHK) begin
				check_value(bus_word(r.addr), r.exp_mem,
					$sformatf("row %0d backing word", i));
			end else begin
				tag = (tag == 8'hff) ? 8'h01 : tag + 8'd1;	// Never zero
				@(posedge clock);
				i_tag <= tag;
				i_mem_read <= (r.op == OP_LOAD);
				i_mem_write <= (r.op == OP_STORE);
				i_mem_flush <= (r.op == OP_FLUSH);
				i_mem_width <= r.width;
				i_mem_signed <= r.sgn;
				i_mem_address <= r.addr;
				i_rd <= r.data;
				i_inst_rd <= tag[4:0];
				@(negedge clock);
				check_value(32'(o_busy), 32'(r.op != OP_PASS), $sformatf("row %0d o_busy", i));
				if (r.op == OP_PASS) begin
					// Pass-through takes one cycle
					@(negedge clock);
					check_value(32'(o_tag), 32'(tag), $sformatf("row %0d o_tag", i));
				end
				while (o_tag != tag)
					@(negedge clock);
				check_value(o_rd, r.exp_rd, $sformatf("row %0d o_rd", i));
				check_value(32'(o_inst_rd), 32'(tag[4:0]), $sformatf("row %0d o_inst_rd", i));
				if (r.chk)
					check_value(bus_word({r.addr[31:2], 2'b00}), r.exp_mem,
						$sformatf("row %0d backing word", i));
			end
			if (i == table_q.size() - 1 || table_q[i+1].test != r.test) begin
				$display("Test %0d %s: %0d rows, %0d mismatches, %s", r.test + 1,
					test_names[r.test], test_rows, test_errors, (test_errors == 0) ? "ok" : "FAIL");
				test_rows = 0;
				test_errors = 0;
			end
		end
		$display("Checks run: %0d, mismatches: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
logic/cpu_memory_pkg.sv
logic/cpu_memory_stage.sv
logic/cpu_dcache.sv
logic/cpu_memory_subsystem.sv
tb/tb_clock_gen.sv
tb/cpu_memory_properties.sv
tb/tb_memory_subsystem.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_memory_subsystem
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Fails unless the pass line shows up in the simulation output
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
